// File: common/dcache_pkg.sv
// data cache shared definitions
package dcache_pkg;

  // address split: tag | index | byte offset
  localparam int ADDR_W         = 16;
  localparam int TAG_W          = 8;
  localparam int IDX_W          = 5;
  localparam int OFS_W          = 3;
  localparam int NUM_LINES      = 32;
  localparam int LINE_W         = 64;
  localparam int BYTES_PER_LINE = 8;

  // slots the memory side can hold before it returns a credit
  localparam int MEM_CREDITS = 2;
  localparam int CREDIT_W    = $clog2(MEM_CREDITS + 1);

  typedef enum logic [1:0] {
    REG_CTRL   = 2'd0,
    REG_HITS   = 2'd1,
    REG_MISSES = 2'd2,
    REG_WBACKS = 2'd3
  } cfg_addr_e;

  typedef struct packed {
    logic                      write;
    logic [ADDR_W-1:0]         addr;
    logic [LINE_W-1:0]         wdata;
    logic [BYTES_PER_LINE-1:0] byte_en;
  } cpu_req_t;

  typedef struct packed {
    logic [LINE_W-1:0] rdata;
    logic              hit;
  } cpu_rsp_t;

  // addr is always line aligned
  typedef struct packed {
    logic                      write;
    logic [ADDR_W-1:0]         addr;
    logic [LINE_W-1:0]         wdata;
    logic [BYTES_PER_LINE-1:0] byte_en;
  } mem_req_t;

  typedef struct packed {
    logic [LINE_W-1:0] data;
  } mem_rsp_t;

  // one-cycle pulses toward the counters
  typedef struct packed {
    logic hit;
    logic miss;
    logic wback;
  } cache_event_t;

  // replace the enabled bytes of a line
  function automatic logic [LINE_W-1:0] merge_bytes(
    input logic [LINE_W-1:0]         old_line,
    input logic [LINE_W-1:0]         new_data,
    input logic [BYTES_PER_LINE-1:0] mask
  );
    logic [LINE_W-1:0] result;
    result = old_line;
    for (int b = 0; b < BYTES_PER_LINE; b++) begin
      if (mask[b]) begin
        result[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic [ADDR_W-1:0] line_addr(
    input logic [TAG_W-1:0] tag,
    input logic [IDX_W-1:0] idx
  );
    return {tag, idx, {OFS_W{1'b0}}};
  endfunction

endpackage

// File: dcache/dcache_mem.sv
// data cache line storage
`timescale 1ns/1ps

module dcache_mem import dcache_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  // lookup port, also selects the line for store and refill
  input  logic [IDX_W-1:0]  lookup_idx,
  input  logic [TAG_W-1:0]  lookup_tag,
  output logic              lookup_hit,
  output logic [LINE_W-1:0] lookup_data,
  output logic              victim_dirty,
  output logic [TAG_W-1:0]  victim_tag,
  // store port
  input  logic              store_en,
  input  logic [LINE_W-1:0] store_data,
  input  logic [7:0]        store_mask,
  // refill port
  input  logic              refill_en,
  input  logic [LINE_W-1:0] refill_data,
  input  logic              refill_dirty
);

  logic [LINE_W-1:0]    data_q [NUM_LINES];
  logic [TAG_W-1:0]     tag_q  [NUM_LINES];
  logic [NUM_LINES-1:0] valid_q;
  logic [NUM_LINES-1:0] dirty_q;

  logic [LINE_W-1:0] cur_line;
  logic [TAG_W-1:0]  cur_tag;
  logic              cur_valid;
  logic              cur_dirty;

  assign cur_line  = data_q[lookup_idx];
  assign cur_tag   = tag_q[lookup_idx];
  assign cur_valid = valid_q[lookup_idx];
  assign cur_dirty = dirty_q[lookup_idx];

  // combinational lookup in the request cycle
  assign lookup_hit  = cur_valid && (cur_tag == lookup_tag);
  assign lookup_data = cur_line;

  // the line sitting at the index is the one a refill would evict
  assign victim_dirty = cur_valid && cur_dirty;
  assign victim_tag   = cur_tag;

  // valid and dirty flags
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (refill_en) begin
      valid_q[lookup_idx] <= 1'b1;
      dirty_q[lookup_idx] <= refill_dirty;
    end else if (store_en) begin
      dirty_q[lookup_idx] <= 1'b1;
    end
  end

  // line payload and tags
  always_ff @(posedge clock) begin
    if (refill_en) begin
      data_q[lookup_idx] <= refill_data;
      tag_q[lookup_idx]  <= lookup_tag;
    end else if (store_en) begin
      data_q[lookup_idx] <= merge_bytes(cur_line, store_data, store_mask);
    end
  end

  // the controller serializes stores and refills
  a_one_write_port: assert property (
    @(posedge clock) disable iff (reset)
    !(store_en && refill_en)
  ) else $error("dcache_mem: store and refill in the same cycle");

  // a store on a miss would corrupt another address's line
  a_store_on_hit: assert property (
    @(posedge clock) disable iff (reset)
    store_en |-> lookup_hit
  ) else $error("dcache_mem: store without a hit");

endmodule

// File: dcache/dcache_ctrl.sv
// data cache controller
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  // client side
  input  logic              req_valid,
  output logic              req_ready,
  input  cpu_req_t          req,
  output logic              rsp_valid,
  output cpu_rsp_t          rsp,
  // memory side
  output logic              mem_req_valid,
  output mem_req_t          mem_req,
  input  logic              mem_credit_return,
  input  logic              mem_rsp_valid,
  input  mem_rsp_t          mem_rsp,
  input  logic              write_allocate,
  // storage side
  output logic [IDX_W-1:0]  lookup_idx,
  output logic [TAG_W-1:0]  lookup_tag,
  input  logic              lookup_hit,
  input  logic [LINE_W-1:0] lookup_data,
  input  logic              victim_dirty,
  input  logic [TAG_W-1:0]  victim_tag,
  output logic              store_en,
  output logic [LINE_W-1:0] store_data,
  output logic [7:0]        store_mask,
  output logic              refill_en,
  output logic [LINE_W-1:0] refill_data,
  output logic              refill_dirty,
  output cache_event_t      events
);

  typedef enum logic [2:0] {
    IDLE, LOOKUP, WBACK, FETCH, WAIT_FILL, RESPOND
  } state_e;

  state_e              state_q, state_d;
  cpu_req_t            req_q;
  cpu_rsp_t            rsp_q;
  logic                ready_q;
  logic [CREDIT_W-1:0] credits_q;
  logic                accept;
  logic                have_credit;
  logic [ADDR_W-1:0]   cur_addr;
  logic [LINE_W-1:0]   fill_line;

  assign req_ready   = ready_q;
  assign accept      = req_valid && req_ready;
  assign have_credit = (credits_q != '0);

  // a new request is looked up directly and later states use the latched one
  assign cur_addr   = (state_q == IDLE) ? req.addr : req_q.addr;
  assign lookup_tag = cur_addr[ADDR_W-1 -: TAG_W];
  assign lookup_idx = cur_addr[OFS_W +: IDX_W];

  assign store_data = req.wdata;
  assign store_mask = req.byte_en;

  // a store miss installs the refilled line with its bytes already merged
  assign fill_line = req_q.write ? merge_bytes(mem_rsp.data, req_q.wdata, req_q.byte_en)
                                 : mem_rsp.data;
  assign refill_data  = fill_line;
  assign refill_dirty = req_q.write;

  assign rsp_valid = (state_q == RESPOND);
  assign rsp       = rsp_q;

  always_comb begin
    state_d       = state_q;
    mem_req_valid = 1'b0;
    mem_req       = '0;
    store_en      = 1'b0;
    refill_en     = 1'b0;
    events        = '0;
    case (state_q)
      IDLE: begin
        if (accept) begin
          events.hit  = lookup_hit;
          events.miss = !lookup_hit;
          store_en    = req.write && lookup_hit;
          state_d     = lookup_hit ? RESPOND : LOOKUP;
        end
      end
      LOOKUP: begin
        if (req_q.write && !write_allocate) begin
          // no-allocate store goes straight to memory
          if (have_credit) begin
            mem_req_valid   = 1'b1;
            mem_req.write   = 1'b1;
            mem_req.addr    = line_addr(lookup_tag, lookup_idx);
            mem_req.wdata   = req_q.wdata;
            mem_req.byte_en = req_q.byte_en;
            state_d         = RESPOND;
          end
        end else begin
          state_d = victim_dirty ? WBACK : FETCH;
        end
      end
      WBACK: begin
        if (have_credit) begin
          mem_req_valid   = 1'b1;
          mem_req.write   = 1'b1;
          mem_req.addr    = line_addr(victim_tag, lookup_idx);
          mem_req.wdata   = lookup_data;
          mem_req.byte_en = '1;
          events.wback    = 1'b1;
          state_d         = FETCH;
        end
      end
      FETCH: begin
        if (have_credit) begin
          mem_req_valid = 1'b1;
          mem_req.addr  = line_addr(lookup_tag, lookup_idx);
          state_d       = WAIT_FILL;
        end
      end
      WAIT_FILL: begin
        if (mem_rsp_valid) begin
          refill_en = 1'b1;
          state_d   = RESPOND;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q   <= IDLE;
      ready_q   <= 1'b0;
      credits_q <= CREDIT_W'(MEM_CREDITS);
    end else begin
      state_q   <= state_d;
      ready_q   <= (state_d == IDLE);
      credits_q <= credits_q - CREDIT_W'(mem_req_valid) + CREDIT_W'(mem_credit_return);
    end
  end

  // request and response payload
  always_ff @(posedge clock) begin
    if (accept) begin
      req_q <= req;
    end
    if (accept && lookup_hit) begin
      rsp_q.rdata <= req.write ? merge_bytes(lookup_data, req.wdata, req.byte_en)
                               : lookup_data;
      rsp_q.hit   <= 1'b1;
    end else if (state_q == LOOKUP && state_d == RESPOND) begin
      rsp_q <= '0;
    end else if (refill_en) begin
      rsp_q.rdata <= fill_line;
      rsp_q.hit   <= 1'b0;
    end
  end

  // memory must not return more credits than it was given
  a_credit_range: assert property (
    @(posedge clock) disable iff (reset)
    credits_q <= CREDIT_W'(MEM_CREDITS)
  ) else $error("dcache_ctrl: credit count out of range");

  // read data only ever answers the one refill in flight
  a_rsp_while_waiting: assert property (
    @(posedge clock) disable iff (reset)
    mem_rsp_valid |-> (state_q == WAIT_FILL)
  ) else $error("dcache_ctrl: memory response without a pending refill");

endmodule

// File: dcache/dcache_regs.sv
// data cache control and counters
`timescale 1ns/1ps

module dcache_regs import dcache_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         cfg_wr_en,
  input  cfg_addr_e    cfg_addr,
  input  logic [31:0]  cfg_wdata,
  output logic [31:0]  cfg_rdata,
  input  cache_event_t events,
  output logic         write_allocate
);

  logic [31:0] count_q [1:3];
  logic [3:1]  event_vec;

  // slot i of event_vec pulses the counter at register address i
  assign event_vec = {events.wback, events.miss, events.hit};

  always_ff @(posedge clock) begin
    if (reset) begin
      write_allocate <= 1'b1;
    end else if (cfg_wr_en && cfg_addr == REG_CTRL) begin
      write_allocate <= cfg_wdata[0];
    end
  end

  // a clearing write beats a same-cycle event
  always_ff @(posedge clock) begin
    for (int i = 1; i < 4; i++) begin
      if (reset) begin
        count_q[i] <= '0;
      end else if (cfg_wr_en && cfg_addr == cfg_addr_e'(i)) begin
        count_q[i] <= '0;
      end else if (event_vec[i]) begin
        count_q[i] <= count_q[i] + 32'd1;
      end
    end
  end

  always_comb begin
    case (cfg_addr)
      REG_CTRL:   cfg_rdata = {31'b0, write_allocate};
      REG_HITS:   cfg_rdata = count_q[1];
      REG_MISSES: cfg_rdata = count_q[2];
      default:    cfg_rdata = count_q[3];
    endcase
  end

endmodule

// File: verilog/dcache_top.sv
// write-back data cache top
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        req_valid,
  output logic        req_ready,
  input  cpu_req_t    req,
  output logic        rsp_valid,
  output cpu_rsp_t    rsp,
  output logic        mem_req_valid,
  output mem_req_t    mem_req,
  input  logic        mem_credit_return,
  input  logic        mem_rsp_valid,
  input  mem_rsp_t    mem_rsp,
  input  logic        cfg_wr_en,
  input  cfg_addr_e   cfg_addr,
  input  logic [31:0] cfg_wdata,
  output logic [31:0] cfg_rdata
);

  logic [IDX_W-1:0]  lookup_idx;
  logic [TAG_W-1:0]  lookup_tag;
  logic              lookup_hit;
  logic [LINE_W-1:0] lookup_data;
  logic              victim_dirty;
  logic [TAG_W-1:0]  victim_tag;
  logic              store_en;
  logic [LINE_W-1:0] store_data;
  logic [7:0]        store_mask;
  logic              refill_en;
  logic [LINE_W-1:0] refill_data;
  logic              refill_dirty;
  logic              write_allocate;
  cache_event_t      events;

  dcache_ctrl i_dcache_ctrl (
    .clock, .reset,
    .req_valid, .req_ready, .req, .rsp_valid, .rsp,
    .mem_req_valid, .mem_req, .mem_credit_return, .mem_rsp_valid, .mem_rsp,
    .write_allocate,
    .lookup_idx, .lookup_tag, .lookup_hit, .lookup_data, .victim_dirty, .victim_tag,
    .store_en, .store_data, .store_mask,
    .refill_en, .refill_data, .refill_dirty,
    .events
  );

  dcache_mem i_dcache_mem (
    .clock, .reset,
    .lookup_idx, .lookup_tag, .lookup_hit, .lookup_data, .victim_dirty, .victim_tag,
    .store_en, .store_data, .store_mask,
    .refill_en, .refill_data, .refill_dirty
  );

  dcache_regs i_dcache_regs (
    .clock, .reset,
    .cfg_wr_en, .cfg_addr, .cfg_wdata, .cfg_rdata,
    .events, .write_allocate
  );

endmodule

// File: tb/mem_model.sv
// credit-based memory model
`timescale 1ns/1ps

module mem_model import dcache_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     throttle,
  input  logic     mem_req_valid,
  input  mem_req_t mem_req,
  output logic     mem_credit_return,
  output logic     mem_rsp_valid,
  output mem_rsp_t mem_rsp
);

  logic [7:0]        bytes [logic [ADDR_W-1:0]];
  logic [LINE_W-1:0] read_q [$];
  logic              credit_q = 1'b0;
  logic              valid_q = 1'b0;
  mem_rsp_t          rsp_q = '0;
  int                owed = 0;
  int                credit_wait = 0;
  int                rsp_wait = 0;

  assign mem_credit_return = credit_q;
  assign mem_rsp_valid     = valid_q;
  assign mem_rsp           = rsp_q;

  // bytes never written read back as a function of their address
  function automatic logic [LINE_W-1:0] read_line(input logic [ADDR_W-1:0] base);
    logic [LINE_W-1:0] line;
    logic [ADDR_W-1:0] a;
    for (int b = 0; b < BYTES_PER_LINE; b++) begin
      a = base + ADDR_W'(b);
      if (bytes.exists(a)) begin
        line[8*b +: 8] = bytes[a];
      end else begin
        line[8*b +: 8] = (a[7:0] * 8'd3) ^ a[15:8] ^ 8'ha5;
      end
    end
    return line;
  endfunction

  always @(posedge clock) begin
    if (reset) begin
      credit_q    <= 1'b0;
      valid_q     <= 1'b0;
      owed        = 0;
      credit_wait = 0;
      rsp_wait    = 0;
      read_q.delete();
    end else begin
      credit_q <= 1'b0;
      valid_q  <= 1'b0;
      // at most one slot freed per cycle, after a random gap
      if (credit_wait > 0) begin
        credit_wait--;
      end else if (owed > 0 && (!throttle || $urandom_range(3, 0) == 0)) begin
        credit_q    <= 1'b1;
        owed--;
        credit_wait = $urandom_range(5, 0);
      end
      // reads are answered in order
      if (rsp_wait > 0) begin
        rsp_wait--;
      end else if (read_q.size() > 0) begin
        valid_q    <= 1'b1;
        rsp_q.data <= read_q.pop_front();
        rsp_wait   = $urandom_range(5, 0);
      end
      if (mem_req_valid) begin
        owed++;
        if (mem_req.write) begin
          for (int b = 0; b < BYTES_PER_LINE; b++) begin
            if (mem_req.byte_en[b]) begin
              bytes[mem_req.addr + ADDR_W'(b)] = mem_req.wdata[8*b +: 8];
            end
          end
        end else begin
          read_q.push_back(read_line(mem_req.addr));
        end
      end
    end
  end

endmodule

// File: tb/dcache_tb.sv
// data cache testbench
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

  localparam int TIMEOUT = 200;

  logic        clock = 1'b0;
  logic        reset = 1'b1;
  logic        req_valid = 1'b0;
  cpu_req_t    req = '0;
  logic        req_ready;
  logic        rsp_valid;
  cpu_rsp_t    rsp;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_credit_return;
  logic        mem_rsp_valid;
  mem_rsp_t    mem_rsp;
  logic        cfg_wr_en = 1'b0;
  cfg_addr_e   cfg_addr = REG_CTRL;
  logic [31:0] cfg_wdata = '0;
  logic [31:0] cfg_rdata;
  logic        throttle = 1'b0;

  // reference cache and shadow memory
  logic [LINE_W-1:0] ref_data  [NUM_LINES];
  logic [TAG_W-1:0]  ref_tag   [NUM_LINES];
  bit                ref_valid [NUM_LINES];
  bit                ref_dirty [NUM_LINES];
  logic [LINE_W-1:0] shadow    [logic [ADDR_W-OFS_W-1:0]];
  bit                ref_alloc = 1'b1;
  int                ref_hits = 0;
  int                ref_misses = 0;
  int                ref_wbacks = 0;
  mem_req_t          exp_mem [$];
  mem_req_t          seen_mem [$];
  int                outstanding = 0;
  int                credit_faults = 0;
  int                errors = 0;
  int                tests_passed = 0;
  int                tests_failed = 0;

  always #4 clock = ~clock;

  dcache_top i_dcache_top (.*);
  mem_model  i_mem_model (.*);

  // memory traffic and unreturned credits sampled mid-cycle
  always @(negedge clock) begin
    if (!reset) begin
      if (mem_req_valid) begin
        seen_mem.push_back(mem_req);
      end
      outstanding = outstanding + int'(mem_req_valid) - int'(mem_credit_return);
      if (outstanding > MEM_CREDITS || outstanding < 0) begin
        $display("memory requests without returned credit out of range: %0d", outstanding);
        credit_faults++;
      end
    end
  end

  function automatic logic [LINE_W-1:0] mem_line(input logic [ADDR_W-OFS_W-1:0] key);
    logic [LINE_W-1:0] line;
    logic [ADDR_W-1:0] a;
    if (shadow.exists(key)) begin
      line = shadow[key];
    end else begin
      for (int b = 0; b < BYTES_PER_LINE; b++) begin
        a = {key, 3'(b)};
        line[8*b +: 8] = (a[7:0] * 8'd3) ^ a[15:8] ^ 8'ha5;
      end
    end
    return line;
  endfunction

  function automatic logic [LINE_W-1:0] masked_write(input logic [LINE_W-1:0] old_line,
      input logic [LINE_W-1:0] data, input logic [7:0] mask);
    logic [LINE_W-1:0] sel;
    for (int b = 0; b < BYTES_PER_LINE; b++) begin
      sel[8*b +: 8] = {8{mask[b]}};
    end
    return (old_line & ~sel) | (data & sel);
  endfunction

  // advances the reference model and lists the memory traffic it expects
  function automatic cpu_rsp_t predict(input cpu_req_t r);
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    cpu_rsp_t         exp;
    tag = r.addr[ADDR_W-1 -: TAG_W];
    idx = r.addr[OFS_W +: IDX_W];
    exp_mem.delete();
    if (ref_valid[idx] && ref_tag[idx] == tag) begin
      ref_hits++;
      if (r.write) begin
        ref_data[idx]  = masked_write(ref_data[idx], r.wdata, r.byte_en);
        ref_dirty[idx] = 1'b1;
      end
      exp = '{rdata: ref_data[idx], hit: 1'b1};
    end else if (r.write && !ref_alloc) begin
      ref_misses++;
      exp_mem.push_back('{write: 1'b1, addr: {tag, idx, 3'b0}, wdata: r.wdata,
                          byte_en: r.byte_en});
      shadow[{tag, idx}] = masked_write(mem_line({tag, idx}), r.wdata, r.byte_en);
      exp = '0;
    end else begin
      ref_misses++;
      if (ref_valid[idx] && ref_dirty[idx]) begin
        ref_wbacks++;
        exp_mem.push_back('{write: 1'b1, addr: {ref_tag[idx], idx, 3'b0},
                            wdata: ref_data[idx], byte_en: 8'hff});
        shadow[{ref_tag[idx], idx}] = ref_data[idx];
      end
      exp_mem.push_back('{write: 1'b0, addr: {tag, idx, 3'b0}, wdata: '0, byte_en: '0});
      ref_data[idx]  = masked_write(mem_line({tag, idx}), r.wdata,
                                    r.write ? r.byte_en : 8'h00);
      ref_tag[idx]   = tag;
      ref_valid[idx] = 1'b1;
      ref_dirty[idx] = r.write;
      exp = '{rdata: ref_data[idx], hit: 1'b0};
    end
    return exp;
  endfunction

  task automatic check_rsp(input string name, input cpu_rsp_t exp, input cpu_rsp_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected rdata %h hit %b, actual rdata %h hit %b",
               name, exp.rdata, exp.hit, act.rdata, act.hit);
      errors++;
    end
  endtask

  task automatic check_mem_req(input string name, input mem_req_t exp, input mem_req_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected mem req %b %h %h %h, actual %b %h %h %h",
               name, exp.write, exp.addr, exp.wdata, exp.byte_en,
               act.write, act.addr, act.wdata, act.byte_en);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] exp,
      input logic [31:0] act);
    if (act !== exp) begin
      $display("Mismatch %s: expected count %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  function automatic cpu_req_t random_req(input logic write, input logic [TAG_W-1:0] tag,
      input logic [IDX_W-1:0] idx);
    cpu_req_t r;
    r.write   = write;
    r.addr    = {tag, idx, 3'($urandom_range(7, 0))};
    r.wdata   = {$urandom, $urandom};
    r.byte_en = 8'($urandom);
    return r;
  endfunction

  task automatic do_access(input string name, input cpu_req_t r);
    cpu_rsp_t exp;
    cpu_rsp_t got;
    int       waited;
    int       first;
    bit       ok;
    exp   = predict(r);
    first = seen_mem.size();
    @(posedge clock);
    req_valid <= 1'b1;
    req       <= r;
    waited = 0;
    @(negedge clock);
    while (!req_ready && waited < TIMEOUT) begin
      @(negedge clock);
      waited++;
    end
    ok = req_ready;
    @(posedge clock);
    req_valid <= 1'b0;
    if (!ok) begin
      $display("%s: req_ready stayed low for %0d cycles", name, TIMEOUT);
      errors++;
    end else begin
      waited = 0;
      @(negedge clock);
      while (!rsp_valid && waited < TIMEOUT) begin
        @(negedge clock);
        waited++;
      end
      got = rsp;
      if (!rsp_valid) begin
        $display("%s: no response within %0d cycles", name, TIMEOUT);
        errors++;
      end else begin
        check_rsp(name, exp, got);
        if (seen_mem.size() - first != exp_mem.size()) begin
          $display("%s: expected %0d memory requests, saw %0d", name, exp_mem.size(),
                   seen_mem.size() - first);
          errors++;
        end else begin
          for (int i = 0; i < exp_mem.size(); i++) begin
            check_mem_req(name, exp_mem[i], seen_mem[first + i]);
          end
        end
      end
    end
  endtask

  // small tag and index pools so lines conflict and get evicted
  task automatic random_run(input string name, input int count);
    for (int n = 0; n < count; n++) begin
      do_access(name, random_req(1'($urandom), TAG_W'(8'h11 * (1 + $urandom_range(3, 0))),
                                 IDX_W'(7 * $urandom_range(3, 0))));
    end
  endtask

  task automatic cfg_write(input cfg_addr_e a, input logic [31:0] d);
    @(posedge clock);
    cfg_wr_en <= 1'b1;
    cfg_addr  <= a;
    cfg_wdata <= d;
    @(posedge clock);
    cfg_wr_en <= 1'b0;
  endtask

  task automatic expect_reg(input string name, input cfg_addr_e a, input logic [31:0] exp);
    @(posedge clock);
    cfg_addr <= a;
    @(negedge clock);
    check_count(name, exp, cfg_rdata);
  endtask

  task automatic close_test(input string name, input int start);
    if (errors + credit_faults == start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors + credit_faults - start);
    end
  endtask

  initial begin
    int       start;
    cpu_req_t r;
    void'($urandom(8));
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    start = errors + credit_faults;
    r = random_req(1'b0, 8'h11, 5'd3);
    do_access("load_miss_then_hit", r);
    do_access("load_miss_then_hit", r);
    close_test("load_miss_then_hit", start);

    // one store on a resident line and one that allocates
    start = errors + credit_faults;
    do_access("store_then_load", random_req(1'b1, 8'h11, 5'd3));
    do_access("store_then_load", random_req(1'b0, 8'h11, 5'd3));
    do_access("store_then_load", random_req(1'b1, 8'h55, 5'd9));
    do_access("store_then_load", random_req(1'b0, 8'h55, 5'd9));
    close_test("store_then_load", start);

    // a dirty victim first and then a clean one at the same index
    start = errors + credit_faults;
    do_access("eviction", random_req(1'b0, 8'h66, 5'd3));
    do_access("eviction", random_req(1'b0, 8'h77, 5'd3));
    close_test("eviction", start);

    start = errors + credit_faults;
    cfg_write(REG_CTRL, 32'd0);
    ref_alloc = 1'b0;
    expect_reg("no_allocate", REG_CTRL, 32'd0);
    do_access("no_allocate", random_req(1'b1, 8'h88, 5'd12));
    do_access("no_allocate", random_req(1'b0, 8'h88, 5'd12));
    cfg_write(REG_CTRL, 32'd1);
    ref_alloc = 1'b1;
    close_test("no_allocate", start);

    start = errors + credit_faults;
    cfg_write(REG_HITS, 32'd0);
    cfg_write(REG_MISSES, 32'd0);
    cfg_write(REG_WBACKS, 32'd0);
    ref_hits   = 0;
    ref_misses = 0;
    ref_wbacks = 0;
    random_run("counters", 300);
    expect_reg("counters", REG_HITS, 32'(ref_hits));
    expect_reg("counters", REG_MISSES, 32'(ref_misses));
    expect_reg("counters", REG_WBACKS, 32'(ref_wbacks));
    // any written value clears a counter
    cfg_write(REG_HITS, 32'hffff_ffff);
    cfg_write(REG_MISSES, 32'hffff_ffff);
    cfg_write(REG_WBACKS, 32'hffff_ffff);
    expect_reg("counters", REG_HITS, 32'd0);
    expect_reg("counters", REG_MISSES, 32'd0);
    expect_reg("counters", REG_WBACKS, 32'd0);
    close_test("counters", start);

    // memory holds credits back at random
    start = errors + credit_faults;
    @(posedge clock);
    throttle <= 1'b1;
    random_run("credits", 100);
    @(posedge clock);
    throttle <= 1'b0;
    close_test("credits", start);

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors + credit_faults == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: project.f
common/dcache_pkg.sv
dcache/dcache_mem.sv
dcache/dcache_ctrl.sv
dcache/dcache_regs.sv
verilog/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module dcache_tb -o dcache_sim \
  && ./obj_dir/dcache_sim > sim.log 2>&1
grep -q "Simulation completed successfully" sim.log && echo "run passed" \
  || { echo "run failed, see sim.log"; exit 1; }
